/* common/alu_pkg.sv */
package alu_pkg;

  // Data word carried on the bus and between units.
  typedef logic [31:0] word_t;

  // Single precision pattern. Sign 31, exponent 30:23, mantissa 22:0.
  typedef logic [31:0] float_t;

  // Op codes. Bit 3 set means the float unit.
  typedef enum logic [3:0] {
    ALU_ADD         = 4'd0,
    ALU_SUB         = 4'd1,
    ALU_AND         = 4'd2,
    ALU_OR          = 4'd3,
    ALU_XOR         = 4'd4,
    ALU_SLL         = 4'd5,
    ALU_SRL         = 4'd6,
    ALU_F_INT_FLOAT = 4'd8,
    ALU_F_FLOAT_INT = 4'd9,
    ALU_F_ADD       = 4'd10
  } alu_op_t;

  localparam int FLOAT_BIAS = 127;  // Exponent bias.

  // Word addresses of the register map.
  localparam int REG_OPA    = 0;
  localparam int REG_OPB    = 1;
  localparam int REG_OP     = 2;  // Writing here starts a job.
  localparam int REG_RESULT = 3;
  localparam int REG_STATUS = 4;  // Bit 0 is busy.

endpackage

/* dsp_float/float_add.sv */
`timescale 1ns/1ns

module float_add (
  input  alu_pkg::float_t a,
  input  alu_pkg::float_t b,
  output alu_pkg::float_t sum
);

  logic            a_zero;
  logic            b_zero;
  logic            a_bigger;
  alu_pkg::float_t big_op;
  alu_pkg::float_t small_op;
  logic [7:0]      exp_diff;
  logic [23:0]     big_man;
  logic [23:0]     small_man;
  logic [24:0]     man_sum;
  logic [4:0]      lead_pos;
  logic [4:0]      norm_shift;
  logic [23:0]     man_norm;

  assign a_zero = (a[30:23] == 8'd0);  // Exponent zero counts as zero.
  assign b_zero = (b[30:23] == 8'd0);

  // Exponent then mantissa, so this is a magnitude compare.
  assign a_bigger = (a[30:0] >= b[30:0]);
  assign big_op   = a_bigger ? a : b;
  assign small_op = a_bigger ? b : a;

  // Align the smaller one. Bits shifted out are lost.
  assign exp_diff  = big_op[30:23] - small_op[30:23];
  assign big_man   = {1'b1, big_op[22:0]};
  assign small_man = {1'b1, small_op[22:0]} >> exp_diff;

  // Same signs add, different signs subtract. Never negative since big is larger.
  assign man_sum = (a[31] == b[31]) ? {1'b0, big_man} + {1'b0, small_man}
                                    : {1'b0, big_man} - {1'b0, small_man};

  // Leading-one search over the low 24 bits.
  always_comb begin
    lead_pos = 5'd0;
    for (int i = 0; i < 24; i++) begin
      if (man_sum[i]) begin
        lead_pos = 5'(i);
      end
    end
  end

  assign norm_shift = 5'd23 - lead_pos;
  assign man_norm   = man_sum[23:0] << norm_shift;

  always_comb begin
    if (a_zero) begin
      sum = b_zero ? '0 : b;  // Pass the other operand.
    end else if (b_zero) begin
      sum = a;
    end else if (man_sum == 25'd0) begin
      sum = '0;  // Exact cancellation.
    end else if (man_sum[24]) begin
      sum = {big_op[31], big_op[30:23] + 8'd1, man_sum[23:1]};  // Carry out.
    end else if (big_op[30:23] <= {3'd0, norm_shift}) begin
      sum = '0;  // Would need a denormal.
    end else begin
      sum = {big_op[31], big_op[30:23] - {3'd0, norm_shift}, man_norm[22:0]};
    end
  end

endmodule

/* dsp_float/dsp_float.sv */
`timescale 1ns/1ns

module dsp_float (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  alu_pkg::alu_op_t alu_op,
  input  alu_pkg::word_t   left_operand,
  input  alu_pkg::word_t   right_operand,
  output alu_pkg::word_t   result,
  output logic             done
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_SCAN,
    S_FINISH
  } i2f_state_t;

  i2f_state_t     state;
  logic [5:0]     scan_cnt;   // Scan cycle counter.
  logic           i2f_sign;
  alu_pkg::word_t i2f_mag;    // Magnitude kept for the mantissa.
  alu_pkg::word_t i2f_shift;  // Copy that is shifted during the scan.
  logic [4:0]     lead_pos;   // Highest set bit seen so far.
  logic           found;      // Any set bit seen.
  logic [54:0]    i2f_man_long;
  logic [7:0]     i2f_exp;
  alu_pkg::float_t i2f_value;

  logic           quick_done;
  alu_pkg::word_t quick_res;

  logic [7:0]     f2i_exp;
  logic [4:0]     f2i_shamt;
  logic [54:0]    f2i_wide;
  alu_pkg::word_t f2i_mag;
  alu_pkg::word_t f2i_value;
  alu_pkg::float_t add_sum;

  // Int-to-float assembly from the scan result.
  assign i2f_man_long = {i2f_mag, 23'd0} >> lead_pos;  // Leading one lands on bit 23.
  assign i2f_exp      = {3'd0, lead_pos} + 8'(alu_pkg::FLOAT_BIAS);
  assign i2f_value    = found ? {i2f_sign, i2f_exp, i2f_man_long[22:0]} : '0;

  // Float-to-int, truncating toward zero.
  assign f2i_exp   = left_operand[30:23];
  assign f2i_shamt = 5'(f2i_exp - 8'(alu_pkg::FLOAT_BIAS));
  assign f2i_wide  = {31'd0, 1'b1, left_operand[22:0]} << f2i_shamt;
  assign f2i_mag   = f2i_wide[54:23];  // Drop the fraction bits.

  always_comb begin
    if (f2i_exp < 8'(alu_pkg::FLOAT_BIAS)) begin
      f2i_value = '0;  // Below one. Also covers exponent zero.
    end else if (f2i_exp >= 8'(alu_pkg::FLOAT_BIAS + 31)) begin
      f2i_value = left_operand[31] ? 32'h8000_0000 : 32'h7fff_ffff;  // Saturate.
    end else if (left_operand[31]) begin
      f2i_value = ~f2i_mag + 32'd1;
    end else begin
      f2i_value = f2i_mag;
    end
  end

  float_add u_float_add (
    .a   (left_operand),
    .b   (right_operand),
    .sum (add_sum)
  );

  // Single-cycle ops. Result loaded with start.
  always_ff @(posedge clk) begin
    if (start) begin
      case (alu_op)
        alu_pkg::ALU_F_FLOAT_INT: quick_res <= f2i_value;
        alu_pkg::ALU_F_ADD:       quick_res <= add_sum;
        default:                  quick_res <= '0;
      endcase
    end
  end

  // Int-to-float state machine. One load cycle, then 32 scan cycles.
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      scan_cnt   <= '0;
      quick_done <= 1'b0;
    end else begin
      quick_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            if (alu_op == alu_pkg::ALU_F_INT_FLOAT) begin
              state    <= S_SCAN;
              scan_cnt <= '0;
            end else begin
              quick_done <= 1'b1;  // Anything else finishes next cycle.
            end
          end
        end
        S_SCAN: begin
          scan_cnt <= scan_cnt + 6'd1;
          if (scan_cnt == 6'd31) begin
            state <= S_FINISH;
          end
        end
        default: state <= S_IDLE;  // Finish lasts one cycle.
      endcase
    end
  end

  // Scan datapath.
  always_ff @(posedge clk) begin
    if (state == S_IDLE && start) begin
      i2f_sign  <= left_operand[31];
      i2f_mag   <= left_operand[31] ? ~left_operand + 32'd1 : left_operand;
      i2f_shift <= left_operand[31] ? ~left_operand + 32'd1 : left_operand;
      found     <= 1'b0;
      lead_pos  <= '0;
    end else if (state == S_SCAN) begin
      i2f_shift <= i2f_shift >> 1;
      if (i2f_shift[0]) begin
        lead_pos <= scan_cnt[4:0];  // Later hits overwrite, so the top bit wins.
        found    <= 1'b1;
      end
    end
  end

  assign done   = quick_done | (state == S_FINISH);
  assign result = (state == S_FINISH) ? i2f_value : quick_res;

  scan_bound: assert property (@(posedge clk) disable iff (rst)
    scan_cnt <= 6'd31 || state != S_SCAN);

endmodule

/* verilog/alu_int.sv */
`timescale 1ns/1ns

module alu_int (
  input  logic             clk,
  input  logic             rst,
  input  logic             start,
  input  alu_pkg::alu_op_t alu_op,
  input  alu_pkg::word_t   left_operand,
  input  alu_pkg::word_t   right_operand,
  output alu_pkg::word_t   result,
  output logic             done
);

  alu_pkg::word_t int_value;
  logic [4:0]     shamt;

  assign shamt = right_operand[4:0];  // Only five bits matter for a 32-bit shift.

  // Operation select.
  always_comb begin
    case (alu_op)
      alu_pkg::ALU_ADD: int_value = left_operand + right_operand;
      alu_pkg::ALU_SUB: int_value = left_operand - right_operand;
      alu_pkg::ALU_AND: int_value = left_operand & right_operand;
      alu_pkg::ALU_OR:  int_value = left_operand | right_operand;
      alu_pkg::ALU_XOR: int_value = left_operand ^ right_operand;
      alu_pkg::ALU_SLL: int_value = left_operand << shamt;
      alu_pkg::ALU_SRL: int_value = left_operand >> shamt;  // Logical, zero fill.
      default:          int_value = '0;  // Float codes never reach here.
    endcase
  end

  // Result register, loaded only on start.
  always_ff @(posedge clk) begin
    if (start) begin
      result <= int_value;
    end
  end

  // Done follows start by one clock.
  always_ff @(posedge clk) begin
    if (rst) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

endmodule

/* verilog/alu_wb_slave.sv */
`timescale 1ns/1ns

module alu_wb_slave #(
  parameter int WB_ADDR_W = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [WB_ADDR_W-1:0] wb_adr,
  input  alu_pkg::word_t       wb_dat_w,
  output alu_pkg::word_t       wb_dat_r,
  output logic                 wb_ack,
  input  logic                 int_done,
  input  alu_pkg::word_t       int_result,
  input  logic                 float_done,
  input  alu_pkg::word_t       float_result,
  output alu_pkg::word_t       left_operand,
  output alu_pkg::word_t       right_operand,
  output alu_pkg::alu_op_t     alu_op,
  output logic                 start_int,
  output logic                 start_float
);

  logic           wb_req;
  logic           busy;
  logic           launch;  // Op accepted, start goes out next clock.
  logic           locked;
  alu_pkg::word_t result_q;
  alu_pkg::word_t rd_data;

  assign wb_req = wb_cyc & wb_stb & ~wb_ack;  // Ack cycle is not a new request.
  assign locked = busy | launch;              // Register writes dropped while set.

  // Word-addressed read mux.
  always_comb begin
    case (wb_adr)
      WB_ADDR_W'(alu_pkg::REG_OPA):    rd_data = left_operand;
      WB_ADDR_W'(alu_pkg::REG_OPB):    rd_data = right_operand;
      WB_ADDR_W'(alu_pkg::REG_OP):     rd_data = {28'd0, alu_op};
      WB_ADDR_W'(alu_pkg::REG_RESULT): rd_data = result_q;
      WB_ADDR_W'(alu_pkg::REG_STATUS): rd_data = {31'd0, busy};
      default:                         rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack        <= 1'b0;
      wb_dat_r      <= '0;
      left_operand  <= '0;
      right_operand <= '0;
      alu_op        <= alu_pkg::ALU_ADD;
      result_q      <= '0;
      busy          <= 1'b0;
      launch        <= 1'b0;
      start_int     <= 1'b0;
      start_float   <= 1'b0;
    end else begin
      wb_ack      <= wb_req;  // Fixed one-cycle ack.
      launch      <= 1'b0;
      start_int   <= launch & ~alu_op[3];  // Top bit picks the unit.
      start_float <= launch & alu_op[3];
      if (launch) begin
        busy <= 1'b1;
      end
      // Either unit may finish. Only one is ever running.
      if (int_done) begin
        result_q <= int_result;
        busy     <= 1'b0;
      end
      if (float_done) begin
        result_q <= float_result;
        busy     <= 1'b0;
      end
      if (wb_req && wb_we && !locked) begin
        case (wb_adr)
          WB_ADDR_W'(alu_pkg::REG_OPA): left_operand  <= wb_dat_w;
          WB_ADDR_W'(alu_pkg::REG_OPB): right_operand <= wb_dat_w;
          WB_ADDR_W'(alu_pkg::REG_OP): begin
            alu_op <= alu_pkg::alu_op_t'(wb_dat_w[3:0]);
            launch <= 1'b1;
          end
          default: ;  // Result and status are read only.
        endcase
      end
      if (wb_req && !wb_we) begin
        wb_dat_r <= rd_data;  // Valid together with ack.
      end
    end
  end

  ack_after_request: assert property (@(posedge clk) disable iff (rst)
    $rose(wb_ack) |-> $past(wb_cyc && wb_stb));

  single_start: assert property (@(posedge clk) disable iff (rst)
    !(start_int && start_float));

endmodule

/* verilog/dsp_alu_top.sv */
`timescale 1ns/1ns

module dsp_alu_top #(
  parameter int WB_ADDR_W = 4
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  logic [WB_ADDR_W-1:0] wb_adr,
  input  alu_pkg::word_t       wb_dat_w,
  output alu_pkg::word_t       wb_dat_r,
  output logic                 wb_ack
);

  alu_pkg::word_t   left_operand;
  alu_pkg::word_t   right_operand;
  alu_pkg::alu_op_t alu_op;
  logic             start_int;
  logic             start_float;
  logic             int_done;
  logic             float_done;
  alu_pkg::word_t   int_result;
  alu_pkg::word_t   float_result;

  // Bus side. Owns the registers and the busy flag.
  alu_wb_slave #(
    .WB_ADDR_W (WB_ADDR_W)
  ) u_alu_wb_slave (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .int_done      (int_done),
    .int_result    (int_result),
    .float_done    (float_done),
    .float_result  (float_result),
    .left_operand  (left_operand),
    .right_operand (right_operand),
    .alu_op        (alu_op),
    .start_int     (start_int),
    .start_float   (start_float)
  );

  alu_int u_alu_int (
    .clk           (clk),
    .rst           (rst),
    .start         (start_int),
    .alu_op        (alu_op),
    .left_operand  (left_operand),
    .right_operand (right_operand),
    .result        (int_result),
    .done          (int_done)
  );

  dsp_float u_dsp_float (
    .clk           (clk),
    .rst           (rst),
    .start         (start_float),
    .alu_op        (alu_op),
    .left_operand  (left_operand),
    .right_operand (right_operand),
    .result        (float_result),
    .done          (float_done)
  );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  initial begin
    clk = 1'b0;  // Known level at time zero.
  end

  always #20 clk = ~clk;  // 40 ns period.

endmodule

/* sim/dsp_alu_tb.sv */
`timescale 1ns/1ns

module dsp_alu_tb;

  logic           clk;
  logic           rst;
  logic           wb_cyc;
  logic           wb_stb;
  logic           wb_we;
  logic [3:0]     wb_adr;
  alu_pkg::word_t wb_dat_w;
  alu_pkg::word_t wb_dat_r;
  logic           wb_ack;

  int   value_errors;
  int   bus_errors;  // Missing or extra acks, timeouts.
  logic stalled;     // Set once the bus gives up. Later accesses are skipped.

  tb_clock u_tb_clock (
    .clk (clk)
  );

  dsp_alu_top #(
    .WB_ADDR_W (4)
  ) u_dsp_alu_top (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  task automatic check_word(input string name, input alu_pkg::word_t got,
                            input alu_pkg::word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_float(input string name, input alu_pkg::float_t got,
                             input alu_pkg::float_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0t ns: %s is float %h, expected float %h", $time, name, got, exp);
    end
  endtask

  // One classic cycle. Drive on the falling edge, sample there too.
  task automatic bus_cycle(input logic we, input int adr, input alu_pkg::word_t wdata,
                           output alu_pkg::word_t rdata);
    int wait_cnt;
    rdata = '0;
    if (stalled) return;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = 4'(adr);
    wb_dat_w = wdata;
    wait_cnt = 0;
    do begin
      @(negedge clk);
      wait_cnt++;
    end while (!wb_ack && wait_cnt < 10);
    if (!wb_ack) begin
      $display("Timeout: register %0d access was never acknowledged", adr);
      bus_errors++;
      stalled = 1'b1;
    end
    rdata  = wb_dat_r;  // Valid with ack.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(negedge clk);
    if (wb_ack) begin
      $display("Register %0d access got a second ack at %0t ns", adr, $time);
      bus_errors++;
    end
  endtask

  task automatic wb_write(input int adr, input alu_pkg::word_t data);
    alu_pkg::word_t unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input int adr, output alu_pkg::word_t data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  // Poll busy. With watch set, the result must hold its old value meanwhile.
  task automatic wait_idle(input logic watch, input alu_pkg::word_t old_result);
    alu_pkg::word_t status;
    alu_pkg::word_t res;
    int             polls;
    polls  = 0;
    status = 32'd1;
    while (status[0] && polls < 100 && !stalled) begin
      wb_read(alu_pkg::REG_RESULT, res);  // Read first, so a busy status covers it.
      wb_read(alu_pkg::REG_STATUS, status);
      if (watch && status[0]) begin
        check_word("REG_RESULT while busy", res, old_result);
      end
      polls++;
    end
    if (status[0] && !stalled) begin
      $display("Timeout: busy bit never cleared");
      bus_errors++;
      stalled = 1'b1;
    end
  endtask

  task automatic run_job(input alu_pkg::alu_op_t op, input alu_pkg::word_t a,
                         input alu_pkg::word_t b, input logic watch,
                         output alu_pkg::word_t result);
    alu_pkg::word_t old_result;
    wb_read(alu_pkg::REG_RESULT, old_result);
    wb_write(alu_pkg::REG_OPA, a);
    wb_write(alu_pkg::REG_OPB, b);
    wb_write(alu_pkg::REG_OP, {28'd0, op});  // Starts the job.
    wait_idle(watch, old_result);
    wb_read(alu_pkg::REG_RESULT, result);
  endtask

  function automatic alu_pkg::word_t int_model(alu_pkg::alu_op_t op, alu_pkg::word_t a,
                                               alu_pkg::word_t b);
    case (op)
      alu_pkg::ALU_ADD: return a + b;
      alu_pkg::ALU_SUB: return a - b;
      alu_pkg::ALU_AND: return a & b;
      alu_pkg::ALU_OR:  return a | b;
      alu_pkg::ALU_XOR: return a ^ b;
      alu_pkg::ALU_SLL: return a << b[4:0];
      alu_pkg::ALU_SRL: return a >> b[4:0];
      default:          return '0;
    endcase
  endfunction

  function automatic alu_pkg::float_t i2f_model(alu_pkg::word_t v);
    logic [31:0] mag;
    logic [31:0] top;
    int          lead;
    if (v == 32'd0) return '0;
    mag  = v[31] ? -v : v;
    lead = 31;
    while (!mag[lead]) lead--;
    top = mag << (31 - lead);  // Leading one on bit 31, rest truncated.
    return {v[31], 8'(lead + alu_pkg::FLOAT_BIAS), top[30:8]};
  endfunction

  function automatic alu_pkg::word_t f2i_model(alu_pkg::float_t f);
    int     e;
    longint mag;
    e = int'(f[30:23]) - alu_pkg::FLOAT_BIAS;
    if (e < 0) return '0;
    if (e >= 31) return f[31] ? 32'h8000_0000 : 32'h7fff_ffff;
    mag = longint'({1'b1, f[22:0]});
    mag = (e >= 23) ? mag << (e - 23) : mag >> (23 - e);  // Toward zero.
    return f[31] ? 32'(-mag) : 32'(mag);
  endfunction

  function automatic alu_pkg::float_t fadd_model(alu_pkg::float_t a, alu_pkg::float_t b);
    alu_pkg::float_t big_op;
    alu_pkg::float_t small_op;
    int              big_exp;
    int              shift;
    longint          mag;
    longint          small_mag;
    if (a[30:23] == 8'd0) return (b[30:23] == 8'd0) ? '0 : b;
    if (b[30:23] == 8'd0) return a;
    big_op    = (a[30:0] >= b[30:0]) ? a : b;
    small_op  = (a[30:0] >= b[30:0]) ? b : a;
    big_exp   = int'(big_op[30:23]);
    shift     = big_exp - int'(small_op[30:23]);
    small_mag = (shift > 24) ? 0 : longint'({1'b1, small_op[22:0]}) >> shift;
    mag       = longint'({1'b1, big_op[22:0]});
    mag       = (a[31] == b[31]) ? mag + small_mag : mag - small_mag;
    if (mag == 0) return '0;
    while (mag >= (longint'(1) << 24)) begin
      mag = mag >> 1;  // Carry drops the low bit.
      big_exp++;
    end
    while (mag < (longint'(1) << 23)) begin
      mag = mag << 1;
      big_exp--;
    end
    if (big_exp <= 0) return '0;  // No denormals.
    return {big_op[31], 8'(big_exp), mag[22:0]};
  endfunction

  task automatic convert_to_float(input alu_pkg::word_t v);
    alu_pkg::word_t res;
    run_job(alu_pkg::ALU_F_INT_FLOAT, v, '0, 1'b1, res);
    check_float($sformatf("REG_RESULT int_to_float(%h)", v), res, i2f_model(v));
  endtask

  task automatic convert_to_int(input alu_pkg::float_t f);
    alu_pkg::word_t res;
    run_job(alu_pkg::ALU_F_FLOAT_INT, f, '0, 1'b0, res);
    check_word($sformatf("REG_RESULT float_to_int(%h)", f), res, f2i_model(f));
  endtask

  task automatic add_floats(input alu_pkg::float_t a, input alu_pkg::float_t b);
    alu_pkg::word_t res;
    run_job(alu_pkg::ALU_F_ADD, a, b, 1'b0, res);
    check_float($sformatf("REG_RESULT %h + %h", a, b), res, fadd_model(a, b));
  endtask

  task automatic register_access();
    alu_pkg::word_t rd;
    alu_pkg::word_t a;
    alu_pkg::word_t b;
    wb_read(alu_pkg::REG_STATUS, rd);
    check_word("REG_STATUS after reset", rd, 32'd0);
    wb_read(alu_pkg::REG_RESULT, rd);
    check_word("REG_RESULT after reset", rd, 32'd0);
    a = $urandom();
    b = $urandom();
    wb_write(alu_pkg::REG_OPA, a);
    wb_write(alu_pkg::REG_OPB, b);
    wb_read(alu_pkg::REG_OPA, rd);
    check_word("REG_OPA", rd, a);
    wb_read(alu_pkg::REG_OPB, rd);
    check_word("REG_OPB", rd, b);
    wb_write(alu_pkg::REG_OP, {28'd0, alu_pkg::ALU_XOR});
    wb_read(alu_pkg::REG_OP, rd);
    check_word("REG_OP", rd, {28'd0, alu_pkg::ALU_XOR});
    wait_idle(1'b0, '0);
    wb_read(alu_pkg::REG_RESULT, rd);
    check_word("REG_RESULT xor", rd, a ^ b);
  endtask

  task automatic integer_ops();
    alu_pkg::alu_op_t ops[7];
    alu_pkg::word_t   a;
    alu_pkg::word_t   b;
    alu_pkg::word_t   res;
    ops = '{alu_pkg::ALU_ADD, alu_pkg::ALU_SUB, alu_pkg::ALU_AND, alu_pkg::ALU_OR,
            alu_pkg::ALU_XOR, alu_pkg::ALU_SLL, alu_pkg::ALU_SRL};
    foreach (ops[i]) begin
      for (int n = 0; n < 4; n++) begin
        a = $urandom();
        b = $urandom();  // Shifts see only the low five bits.
        run_job(ops[i], a, b, 1'b0, res);
        check_word($sformatf("REG_RESULT %s", ops[i].name()), res, int_model(ops[i], a, b));
      end
    end
  endtask

  task automatic int_to_float_cases();
    alu_pkg::word_t fixed[7];
    fixed = '{32'd0, 32'd1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
              32'h0123_4567, 32'hf012_3457};  // Last three exceed 24 bits.
    foreach (fixed[i]) convert_to_float(fixed[i]);
    for (int k = 1; k < 31; k += 6) convert_to_float(32'd1 << k);
    for (int n = 0; n < 3; n++) begin
      convert_to_float($urandom() & 32'h7fff_ffff);
      convert_to_float($urandom() | 32'h8000_0000);
    end
  endtask

  task automatic float_to_int_cases();
    alu_pkg::float_t fixed[13];
    fixed = '{32'h3f00_0000, 32'h3f7f_be77, 32'h3f80_0000, 32'h42c8_0000, 32'h4b80_0000,
              32'hc030_0000, 32'hbf00_0000, 32'h4eff_ffff, 32'h4f00_0000, 32'hcf00_0000,
              32'h60ad_78ec, 32'he0ad_78ec, 32'h0040_0000};
    foreach (fixed[i]) convert_to_int(fixed[i]);
    for (int n = 0; n < 6; n++) begin
      convert_to_int({1'($urandom()), 8'(100 + $urandom() % 70), 23'($urandom())});
    end
  endtask

  task automatic float_add_cases();
    add_floats(32'h3f80_0000, 32'h4000_0000);  // Same sign.
    add_floats(32'h3fc0_0000, 32'h3fc0_0000);  // Carry out.
    add_floats(32'h40a0_0000, 32'hc040_0000);
    add_floats(32'hbf80_0000, 32'h3e80_0000);  // Result negative.
    add_floats(32'h3f80_0000, 32'h3080_0000);  // Small one shifts out.
    add_floats(32'h447a_0000, 32'h3dcc_cccd);
    add_floats(32'h4060_0000, 32'hc060_0000);  // Exact cancellation.
    add_floats(32'h0000_0000, 32'hc020_0000);
    add_floats(32'h40e0_0000, 32'h0000_0000);
    for (int n = 0; n < 6; n++) begin
      add_floats({1'($urandom()), 8'(100 + $urandom() % 50), 23'($urandom())},
                 {1'($urandom()), 8'(100 + $urandom() % 50), 23'($urandom())});
    end
  endtask

  // Writes during a long job are acked and dropped.
  task automatic busy_backpressure();
    alu_pkg::word_t rd;
    alu_pkg::word_t old_b;
    alu_pkg::word_t v;
    v = 32'h00fe_dcba;
    wb_read(alu_pkg::REG_OPB, old_b);
    wb_write(alu_pkg::REG_OPA, v);
    wb_write(alu_pkg::REG_OP, {28'd0, alu_pkg::ALU_F_INT_FLOAT});
    wb_write(alu_pkg::REG_OPA, 32'h1234_5678);
    wb_write(alu_pkg::REG_OPB, old_b + 32'd3);
    wb_write(alu_pkg::REG_OP, {28'd0, alu_pkg::ALU_SUB});
    wb_read(alu_pkg::REG_STATUS, rd);
    check_word("REG_STATUS during job", rd, 32'd1);
    wb_read(alu_pkg::REG_OPA, rd);
    check_word("REG_OPA held while busy", rd, v);
    wb_read(alu_pkg::REG_OPB, rd);
    check_word("REG_OPB held while busy", rd, old_b);
    wb_read(alu_pkg::REG_OP, rd);
    check_word("REG_OP held while busy", rd, {28'd0, alu_pkg::ALU_F_INT_FLOAT});
    wait_idle(1'b0, '0);
    wb_read(alu_pkg::REG_RESULT, rd);
    check_float("REG_RESULT after dropped writes", rd, i2f_model(v));
    run_job(alu_pkg::ALU_SUB, 32'd100, 32'd58, 1'b0, rd);  // Next job runs normally.
    check_word("REG_RESULT after back-pressure", rd, 32'd42);
  endtask

  initial begin
    value_errors = 0;
    bus_errors   = 0;
    stalled      = 1'b0;
    void'($urandom(80));
    rst      = 1'b1;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (8) @(negedge clk);
    rst = 1'b0;
    register_access();
    integer_ops();
    int_to_float_cases();
    float_to_int_cases();
    float_add_cases();
    busy_backpressure();
    $display("Errors: %0d value mismatches, %0d bus or timeout failures",
             value_errors, bus_errors);
    if (value_errors == 0 && bus_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* filelist.f */
common/alu_pkg.sv
dsp_float/float_add.sv
dsp_float/dsp_float.sv
verilog/alu_int.sv
verilog/alu_wb_slave.sv
verilog/dsp_alu_top.sv
sim/tb_clock.sv
sim/dsp_alu_tb.sv

/* run_sim.sh */
#!/bin/bash
# Build with Verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module dsp_alu_tb \
  -f filelist.f > build.log 2>&1 \
  && ./obj_dir/Vdsp_alu_tb > sim.log 2>&1 \
  || { echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -qx "=== PASS ===" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
